//--- all.f
verilog/ex_pkg.sv
verilog/count_bit_word.sv
verilog/mul.sv
verilog/alu.sv
verilog/hilo_reg.sv
verilog/ex_ctrl.sv
verilog/ex_stage.sv
tb/tb_ex_stage.sv

//--- Bender.yml
package:
  name: ex_stage

sources:
  - verilog/ex_pkg.sv
  - verilog/count_bit_word.sv
  - verilog/mul.sv
  - verilog/alu.sv
  - verilog/hilo_reg.sv
  - verilog/ex_ctrl.sv
  - verilog/ex_stage.sv
  - target: test
    files:
      - tb/tb_ex_stage.sv

//--- tb/tb_ex_stage.sv
// self-checking run with fixed LFSR seed; expected outputs follow the ISA rules, not the RTL
`timescale 1ns/1ps

module tb_ex_stage;

    import ex_pkg::*;

    localparam ex_out_t BUBBLE_OUT = '{ACC_D2R, SZ_WORD, 32'h0, 32'h0, 5'h0, 1'b0};

    logic        clk_i;
    logic        rst_n_i;
    ex_in_t      ex_in_i;
    ex_out_t     ex_out_o;
    ex_out_t     exp_now;
    logic [31:0] hi_m;
    logic [31:0] lo_m;
    logic [31:0] lfsr;
    int          cycle;
    int          test_errs;
    int          fail_cnt;
    int          tests_passed;
    int          tests_failed;
    string       test_name;
    op_e         grp[$];

    ex_stage i_ex_stage (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .ex_in_i  (ex_in_i),
        .ex_out_o (ex_out_o)
    );

    always #2 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle <= cycle + 1;
    end

    // --------------------
    // reference model
    // --------------------
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = 32'h0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [31:0] leading_count(input logic [31:0] w, input logic b);
        int n;
        n = 0;
        while (n < 32 && w[31 - n] == b) begin
            n++;
        end
        return n;
    endfunction

    function automatic logic [63:0] full_product(input ex_in_t in);
        logic [63:0] a;
        logic [63:0] b;
        a = {{32{in.rs_value[31] & ~in.is_unsigned}}, in.rs_value};
        b = {{32{in.rt_value[31] & ~in.is_unsigned}}, in.rt_value};
        return a * b;
    endfunction

    function automatic ex_out_t model_out(input ex_in_t in, input logic [31:0] hi,
                                          input logic [31:0] lo);
        ex_out_t     o;
        logic [31:0] sext;
        logic [31:0] b;
        logic [31:0] zb;
        logic [4:0]  fdst;
        logic        ovf;
        sext = {{16{in.imm[15]}}, in.imm};
        b    = (in.op_type == OPT_R) ? in.rt_value : sext;
        zb   = (in.op_type == OPT_R) ? in.rt_value : {16'h0, in.imm};
        fdst = (in.op_type == OPT_R) ? in.rd : in.rt;
        o    = BUBBLE_OUT;
        ovf  = 1'b0;
        case (in.op)
            OP_ADD: begin
                o.data     = in.rs_value + b;
                o.reg_addr = fdst;
                ovf = !in.is_unsigned && (in.rs_value[31] == b[31]) && (o.data[31] != b[31]);
            end
            OP_SUB: begin
                o.data     = in.rs_value - b;
                o.reg_addr = fdst;
                ovf = !in.is_unsigned && (in.rs_value[31] != b[31]) && (o.data[31] == b[31]);
            end
            OP_SLT: begin
                o.data = in.is_unsigned ? {31'b0, in.rs_value < b}
                                        : {31'b0, $signed(in.rs_value) < $signed(b)};
                o.reg_addr = fdst;
            end
            OP_AND, OP_OR, OP_XOR, OP_NOR: begin
                case (in.op)
                    OP_AND:  o.data = in.rs_value & zb;
                    OP_OR:   o.data = in.rs_value | zb;
                    OP_XOR:  o.data = in.rs_value ^ zb;
                    default: o.data = ~(in.rs_value | zb);
                endcase
                o.reg_addr = fdst;
            end
            OP_SLL, OP_SRL, OP_SRA, OP_SLLV, OP_SRLV, OP_SRAV: begin
                case (in.op)
                    OP_SLL:  o.data = in.rt_value << in.imm[10:6];
                    OP_SRL:  o.data = in.rt_value >> in.imm[10:6];
                    OP_SRA:  o.data = $signed(in.rt_value) >>> in.imm[10:6];
                    OP_SLLV: o.data = in.rt_value << in.rs_value[4:0];
                    OP_SRLV: o.data = in.rt_value >> in.rs_value[4:0];
                    default: o.data = $signed(in.rt_value) >>> in.rs_value[4:0];
                endcase
                o.reg_addr = in.rd;
            end
            OP_LUI: begin
                o.data     = {in.imm, 16'h0};
                o.reg_addr = in.rt;
            end
            OP_LB, OP_LH, OP_LW, OP_LL, OP_SB, OP_SH, OP_SW, OP_SC: begin
                o.mem_addr = in.rs_value + sext;
                o.reg_addr = in.rt;
                o.mem_access_op = (in.op inside {OP_SB, OP_SH, OP_SW, OP_SC}) ? ACC_R2M : ACC_M2R;
                o.data = (o.mem_access_op == ACC_R2M) ? in.rt_value : 32'h0;
                o.mem_access_sz = (in.op inside {OP_LB, OP_SB}) ? SZ_BYTE :
                                  (in.op inside {OP_LH, OP_SH}) ? SZ_HALF : SZ_WORD;
            end
            OP_JAL, OP_BGEZAL, OP_BLTZAL, OP_JALR: begin
                o.data     = in.link_addr;
                o.reg_addr = (in.op == OP_JALR) ? in.rd : REG_LINK;
            end
            OP_MFHI, OP_MFLO, OP_MUL, OP_CLO, OP_CLZ: begin
                case (in.op)
                    OP_MFHI: o.data = hi;
                    OP_MFLO: o.data = lo;
                    OP_MUL:  o.data = in.rs_value * in.rt_value;
                    OP_CLO:  o.data = leading_count(in.rs_value, 1'b1);
                    default: o.data = leading_count(in.rs_value, 1'b0);
                endcase
                o.reg_addr = in.rd;
            end
            OP_MOVN, OP_MOVZ: begin
                if ((in.rt_value != 32'h0) == (in.op == OP_MOVN)) begin
                    o.data     = in.rs_value;
                    o.reg_addr = in.rd;
                end
            end
            default: ;
        endcase
        if (ovf) begin
            o.overflow = 1'b1;
            o.data     = 32'h0;
            o.reg_addr = 5'h0;
        end
        return o;
    endfunction

    // shadow HI/LO
    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            hi_m <= 32'h0;
            lo_m <= 32'h0;
        end else begin
            case (ex_in_i.op)
                OP_MTHI: hi_m <= ex_in_i.rs_value;
                OP_MTLO: lo_m <= ex_in_i.rs_value;
                OP_MULT: {hi_m, lo_m} <= full_product(ex_in_i);
                default: ;
            endcase
        end
    end

    assign exp_now = model_out(ex_in_i, hi_m, lo_m);

    // --------------------
    // checks
    // --------------------
    a_reset_bubble: assert property (@(posedge clk_i)
        (cycle > 0 && !$past(rst_n_i)) |-> (ex_out_o == BUBBLE_OUT))
        else begin
            $display("[FAIL] %s expected %h actual %h", test_name, BUBBLE_OUT,
                     $sampled(ex_out_o));
            test_errs++;
            fail_cnt++;
        end

    a_out_matches: assert property (@(posedge clk_i)
        (cycle > 0 && $past(rst_n_i)) |-> (ex_out_o == $past(exp_now)))
        else begin
            $display("[FAIL] %s expected %h actual %h", test_name, $past(exp_now),
                     $sampled(ex_out_o));
            test_errs++;
            fail_cnt++;
        end

    // --------------------
    // stimulus
    // --------------------
    function automatic logic [31:0] operand();
        logic [1:0] sel;
        sel = rand_bits(2);
        if (sel != 2'd0) begin
            return rand_bits(32);
        end
        sel = rand_bits(2);
        case (sel)
            2'd0:    return 32'h7fff_ffff;
            2'd1:    return 32'h8000_0000;
            2'd2:    return 32'h0;
            default: return 32'hffff_ffff;
        endcase
    endfunction

    function automatic ex_in_t make_instr(input op_e op);
        ex_in_t      in;
        logic [31:0] w;
        in.op          = op;
        in.op_type     = (op == OP_JAL) ? OPT_J : (rand_bits(1) ? OPT_R : OPT_I);
        in.link_addr   = rand_bits(32);
        in.rs          = rand_bits(5);
        in.rt          = rand_bits(5);
        in.rd          = rand_bits(5);
        in.rs_value    = operand();
        in.rt_value    = operand();
        w              = operand();
        in.imm         = w[31:16];
        in.is_unsigned = rand_bits(1);
        return in;
    endfunction

    task automatic drive(input ex_in_t in);
        @(negedge clk_i);
        ex_in_i = in;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errs = 0;
    endtask

    task automatic finish_test();
        // let the last results reach the checks
        drive('0);
        drive('0);
        @(negedge clk_i);
        $display("test %-16s %s, %0d errors", test_name, (test_errs == 0) ? "ok" : "FAILED",
                 test_errs);
        if (test_errs == 0) begin
            tests_passed++;
        end else begin
            tests_failed++;
        end
    endtask

    // bounded loop over one opcode group
    task automatic run_group(input int n);
        for (int i = 0; i < n; i++) begin
            drive(make_instr(grp[rand_bits(6) % grp.size()]));
        end
    endtask

    initial begin
        ex_in_t      in;
        int          k;
        logic [31:0] w;
        clk_i        = 1'b0;
        rst_n_i      = 1'b0;
        ex_in_i      = '0;
        lfsr         = 32'hd63;
        cycle        = 0;
        fail_cnt     = 0;
        tests_passed = 0;
        tests_failed = 0;

        start_test("reset_bubble");
        repeat (5) @(negedge clk_i);
        rst_n_i = 1'b1;
        grp = {OP_NOP, OP_DIV, OP_MFC0};
        run_group(24);
        finish_test();

        start_test("arith_trap");
        in = make_instr(OP_ADD);
        in.rs_value    = 32'h7fff_ffff;
        in.rt_value    = 32'h1;
        in.op_type     = OPT_R;
        in.is_unsigned = 1'b0;
        drive(in);
        in.op       = OP_SUB;
        in.rs_value = 32'h8000_0000;
        drive(in);
        in.is_unsigned = 1'b1;
        drive(in);
        grp = {OP_ADD, OP_SUB, OP_SLT};
        run_group(300);
        finish_test();

        start_test("logic_shift");
        grp = {OP_AND, OP_OR, OP_XOR, OP_NOR, OP_LUI, OP_SLL, OP_SRL, OP_SRA,
               OP_SLLV, OP_SRLV, OP_SRAV};
        run_group(400);
        finish_test();

        start_test("mem_access");
        grp = {OP_LB, OP_LH, OP_LW, OP_LL, OP_SB, OP_SH, OP_SW, OP_SC};
        run_group(200);
        finish_test();

        // each write is read back on the next cycle
        start_test("mul_hilo");
        for (int i = 0; i < 150; i++) begin
            grp = {OP_MULT, OP_MTHI, OP_MTLO, OP_MUL};
            run_group(1);
            grp = {OP_MFHI, OP_MFLO};
            run_group(1);
        end
        finish_test();

        start_test("count_move_link");
        for (int i = 0; i < 200; i++) begin
            k = rand_bits(6) % 33;
            w = rand_bits(32) >> k;
            if (k < 32) begin
                w[31 - k] = 1'b1;
            end
            if (rand_bits(1)) begin
                w = ~w;
            end
            in = make_instr(rand_bits(1) ? OP_CLO : OP_CLZ);
            in.rs_value = w;
            drive(in);
        end
        grp = {OP_MOVN, OP_MOVZ, OP_JAL, OP_JALR, OP_BGEZAL, OP_BLTZAL};
        run_group(200);
        finish_test();

        $display("tests passed %0d, tests failed %0d, failing checks %0d",
                 tests_passed, tests_failed, fail_cnt);
        if (tests_failed == 0 && fail_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- verilog/ex_stage.sv
// one-cycle execute stage; caller stalls by feeding NOP, there is no back-pressure
`timescale 1ns/1ps

module ex_stage (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  ex_pkg::ex_in_t  ex_in_i,
    output ex_pkg::ex_out_t ex_out_o
);

    import ex_pkg::*;

    alu_fn_e     alu_fn;
    opnd_e       opnd_sel;
    hilo_wr_e    hilo_wr;
    logic [31:0] alu_result;
    logic        alu_overflow;
    logic [63:0] product;
    logic [31:0] clo_cnt;
    logic [31:0] clz_cnt;
    logic [31:0] hi;
    logic [31:0] lo;

    ex_ctrl i_ex_ctrl (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .ex_in_i        (ex_in_i),
        .alu_result_i   (alu_result),
        .alu_overflow_i (alu_overflow),
        .product_lo_i   (product[31:0]),
        .clo_i          (clo_cnt),
        .clz_i          (clz_cnt),
        .hi_i           (hi),
        .lo_i           (lo),
        .alu_fn_o       (alu_fn),
        .opnd_sel_o     (opnd_sel),
        .hilo_wr_o      (hilo_wr),
        .ex_out_o       (ex_out_o)
    );

    alu i_alu (
        .rs_value_i (ex_in_i.rs_value),
        .rt_value_i (ex_in_i.rt_value),
        .imm_i      (ex_in_i.imm),
        .fn_i       (alu_fn),
        .opnd_i     (opnd_sel),
        .result_o   (alu_result),
        .overflow_o (alu_overflow)
    );

    mul i_mul (
        .op_a_i        (ex_in_i.rs_value),
        .op_b_i        (ex_in_i.rt_value),
        .is_unsigned_i (ex_in_i.is_unsigned),
        .product_o     (product)
    );

    hilo_reg i_hilo_reg (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .wr_i       (hilo_wr),
        .rs_value_i (ex_in_i.rs_value),
        .product_i  (product),
        .hi_o       (hi),
        .lo_o       (lo)
    );

    // leading ones and leading zeros of rs
    count_bit_word i_clo (
        .data_i (ex_in_i.rs_value),
        .bit_i  (1'b1),
        .cnt_o  (clo_cnt)
    );

    count_bit_word i_clz (
        .data_i (ex_in_i.rs_value),
        .bit_i  (1'b0),
        .cnt_o  (clz_cnt)
    );

endmodule

//--- verilog/ex_ctrl.sv
// no handshake; every cycle takes a new instruction and NOP is the only bubble
`timescale 1ns/1ps

module ex_ctrl (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  ex_pkg::ex_in_t   ex_in_i,
    input  logic [31:0]      alu_result_i,
    input  logic             alu_overflow_i,
    input  logic [31:0]      product_lo_i,
    input  logic [31:0]      clo_i,
    input  logic [31:0]      clz_i,
    input  logic [31:0]      hi_i,
    input  logic [31:0]      lo_i,
    output ex_pkg::alu_fn_e  alu_fn_o,
    output ex_pkg::opnd_e    opnd_sel_o,
    output ex_pkg::hilo_wr_e hilo_wr_o,
    output ex_pkg::ex_out_t  ex_out_o
);

    import ex_pkg::*;

    res_src_e    res_src;
    access_op_e  acc_op;
    access_sz_e  acc_sz;
    logic [4:0]  dest;
    logic [4:0]  form_dest;
    logic        is_r;
    logic        rt_nz;
    logic [31:0] data_nxt;
    ex_out_t     ex_out_d;
    ex_out_t     ex_out_q;

    assign is_r      = (ex_in_i.op_type == OPT_R);
    assign form_dest = is_r ? ex_in_i.rd : ex_in_i.rt;
    assign rt_nz     = (ex_in_i.rt_value != 32'h0);

    // --------------------
    // decode
    // --------------------
    always_comb begin
        alu_fn_o   = ALU_ADDU;
        opnd_sel_o = OPND_REG;
        hilo_wr_o  = HILO_NONE;
        res_src    = RES_ZERO;
        dest       = 5'd0;
        acc_op     = ACC_D2R;
        case (ex_in_i.op)
            OP_ADD, OP_SUB, OP_SLT: begin
                opnd_sel_o = is_r ? OPND_REG : OPND_SEXT;
                res_src    = RES_ALU;
                dest       = form_dest;
                case (ex_in_i.op)
                    OP_ADD:  alu_fn_o = ex_in_i.is_unsigned ? ALU_ADDU : ALU_ADD;
                    OP_SUB:  alu_fn_o = ex_in_i.is_unsigned ? ALU_SUBU : ALU_SUB;
                    default: alu_fn_o = ex_in_i.is_unsigned ? ALU_SLTU : ALU_SLT;
                endcase
            end
            OP_AND, OP_OR, OP_XOR, OP_NOR: begin
                opnd_sel_o = is_r ? OPND_REG : OPND_ZEXT;
                res_src    = RES_ALU;
                dest       = form_dest;
                case (ex_in_i.op)
                    OP_AND:  alu_fn_o = ALU_AND;
                    OP_OR:   alu_fn_o = ALU_OR;
                    OP_XOR:  alu_fn_o = ALU_XOR;
                    default: alu_fn_o = ALU_NOR;
                endcase
            end
            OP_SLL, OP_SRL, OP_SRA, OP_SLLV, OP_SRLV, OP_SRAV: begin
                res_src = RES_ALU;
                dest    = ex_in_i.rd;
                case (ex_in_i.op)
                    OP_SLL:  alu_fn_o = ALU_SLL;
                    OP_SRL:  alu_fn_o = ALU_SRL;
                    OP_SRA:  alu_fn_o = ALU_SRA;
                    OP_SLLV: alu_fn_o = ALU_SLLV;
                    OP_SRLV: alu_fn_o = ALU_SRLV;
                    default: alu_fn_o = ALU_SRAV;
                endcase
            end
            OP_LUI: begin
                res_src = RES_LUI;
                dest    = ex_in_i.rt;
            end
            // address is rs plus sign-extended offset through the alu
            OP_LB, OP_LH, OP_LW, OP_LL: begin
                opnd_sel_o = OPND_SEXT;
                acc_op     = ACC_M2R;
                dest       = ex_in_i.rt;
            end
            OP_SB, OP_SH, OP_SW, OP_SC: begin
                opnd_sel_o = OPND_SEXT;
                acc_op     = ACC_R2M;
                res_src    = RES_RT;
                dest       = ex_in_i.rt;
            end
            OP_JAL, OP_BGEZAL, OP_BLTZAL: begin
                res_src = RES_LINK;
                dest    = REG_LINK;
            end
            OP_JALR: begin
                res_src = RES_LINK;
                dest    = ex_in_i.rd;
            end
            OP_MFHI: begin
                res_src = RES_HI;
                dest    = ex_in_i.rd;
            end
            OP_MFLO: begin
                res_src = RES_LO;
                dest    = ex_in_i.rd;
            end
            OP_MTHI: hilo_wr_o = HILO_HI;
            OP_MTLO: hilo_wr_o = HILO_LO;
            OP_MULT: hilo_wr_o = HILO_BOTH;
            OP_MUL, OP_CLO, OP_CLZ: begin
                dest = ex_in_i.rd;
                case (ex_in_i.op)
                    OP_MUL:  res_src = RES_MUL_LO;
                    OP_CLO:  res_src = RES_CLO;
                    default: res_src = RES_CLZ;
                endcase
            end
            // failed condition writes zero to r0
            OP_MOVN, OP_MOVZ: begin
                if (rt_nz == (ex_in_i.op == OP_MOVN)) begin
                    res_src = RES_RS;
                    dest    = ex_in_i.rd;
                end
            end
            default: ;
        endcase
    end

    always_comb begin
        case (ex_in_i.op)
            OP_LB, OP_SB: acc_sz = SZ_BYTE;
            OP_LH, OP_SH: acc_sz = SZ_HALF;
            default:      acc_sz = SZ_WORD;
        endcase
    end

    // --------------------
    // result and register
    // --------------------
    always_comb begin
        case (res_src)
            RES_ALU:    data_nxt = alu_result_i;
            RES_MUL_LO: data_nxt = product_lo_i;
            RES_CLO:    data_nxt = clo_i;
            RES_CLZ:    data_nxt = clz_i;
            RES_HI:     data_nxt = hi_i;
            RES_LO:     data_nxt = lo_i;
            RES_LINK:   data_nxt = ex_in_i.link_addr;
            RES_LUI:    data_nxt = {ex_in_i.imm, 16'h0};
            RES_RS:     data_nxt = ex_in_i.rs_value;
            RES_RT:     data_nxt = ex_in_i.rt_value;
            default:    data_nxt = 32'h0;
        endcase
    end

    always_comb begin
        ex_out_d.mem_access_op = acc_op;
        ex_out_d.mem_access_sz = acc_sz;
        ex_out_d.mem_addr      = (acc_op != ACC_D2R) ? alu_result_i : 32'h0;
        // trap drops the write
        ex_out_d.overflow      = alu_overflow_i;
        ex_out_d.data          = alu_overflow_i ? 32'h0 : data_nxt;
        ex_out_d.reg_addr      = alu_overflow_i ? 5'd0 : dest;
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ex_out_q <= EX_OUT_BUBBLE;
        end else begin
            ex_out_q <= ex_out_d;
        end
    end

    assign ex_out_o = ex_out_q;

    a_mem_op_not_d2r: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (ex_in_i.op inside {OP_LB, OP_LH, OP_LW, OP_LL, OP_SB, OP_SH, OP_SW, OP_SC})
        |=> (ex_out_o.mem_access_op != ACC_D2R))
        else $error("load or store left the stage as D2R");

endmodule

//--- verilog/hilo_reg.sv
// HI and LO clear on reset; a MULT load overrides both halves in one edge
`timescale 1ns/1ps

module hilo_reg (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  ex_pkg::hilo_wr_e wr_i,
    input  logic [31:0]      rs_value_i,
    input  logic [63:0]      product_i,
    output logic [31:0]      hi_o,
    output logic [31:0]      lo_o
);

    import ex_pkg::*;

    logic [31:0] hi_q;
    logic [31:0] lo_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            hi_q <= 32'h0;
            lo_q <= 32'h0;
        end else begin
            case (wr_i)
                HILO_HI: hi_q <= rs_value_i;
                HILO_LO: lo_q <= rs_value_i;
                HILO_BOTH: begin
                    hi_q <= product_i[63:32];
                    lo_q <= product_i[31:0];
                end
                // keep contents
                default: ;
            endcase
        end
    end

    assign hi_o = hi_q;
    assign lo_o = lo_q;

endmodule

//--- verilog/alu.sv
// combinational; shifts act on rt_value, immediate shift amount is imm[10:6]
`timescale 1ns/1ps

module alu (
    input  logic [31:0]     rs_value_i,
    input  logic [31:0]     rt_value_i,
    input  logic [15:0]     imm_i,
    input  ex_pkg::alu_fn_e fn_i,
    input  ex_pkg::opnd_e   opnd_i,
    output logic [31:0]     result_o,
    output logic            overflow_o
);

    import ex_pkg::*;

    logic [31:0] opnd_b;
    logic [31:0] sum;
    logic [31:0] diff;
    logic        add_ovf;
    logic        sub_ovf;
    logic [4:0]  shamt_imm;
    logic [4:0]  shamt_var;

    // --------------------
    // operand selection
    // --------------------
    always_comb begin
        case (opnd_i)
            OPND_SEXT: opnd_b = {{16{imm_i[15]}}, imm_i};
            OPND_ZEXT: opnd_b = {16'b0, imm_i};
            default:   opnd_b = rt_value_i;
        endcase
    end

    assign sum  = rs_value_i + opnd_b;
    assign diff = rs_value_i - opnd_b;

    // signed overflow from operand and result signs
    assign add_ovf = (rs_value_i[31] == opnd_b[31]) && (sum[31] != rs_value_i[31]);
    assign sub_ovf = (rs_value_i[31] != opnd_b[31]) && (diff[31] != rs_value_i[31]);

    assign shamt_imm = imm_i[10:6];
    assign shamt_var = rs_value_i[4:0];

    // --------------------
    // function evaluation
    // --------------------
    always_comb begin
        result_o   = sum;
        overflow_o = 1'b0;
        case (fn_i)
            ALU_ADD: begin
                result_o   = sum;
                overflow_o = add_ovf;
            end
            ALU_ADDU: result_o = sum;
            ALU_SUB: begin
                result_o   = diff;
                overflow_o = sub_ovf;
            end
            ALU_SUBU: result_o = diff;
            ALU_SLT:  result_o = {31'b0, $signed(rs_value_i) < $signed(opnd_b)};
            ALU_SLTU: result_o = {31'b0, rs_value_i < opnd_b};
            ALU_AND:  result_o = rs_value_i & opnd_b;
            ALU_OR:   result_o = rs_value_i | opnd_b;
            ALU_XOR:  result_o = rs_value_i ^ opnd_b;
            ALU_NOR:  result_o = ~(rs_value_i | opnd_b);
            ALU_SLL:  result_o = rt_value_i << shamt_imm;
            ALU_SRL:  result_o = rt_value_i >> shamt_imm;
            ALU_SRA:  result_o = $signed(rt_value_i) >>> shamt_imm;
            ALU_SLLV: result_o = rt_value_i << shamt_var;
            ALU_SRLV: result_o = rt_value_i >> shamt_var;
            ALU_SRAV: result_o = $signed(rt_value_i) >>> shamt_var;
            default:  result_o = sum;
        endcase
    end

    // only the trapping forms may flag overflow
    a_ovf_only_trap_fn: assert final (!overflow_o || (fn_i inside {ALU_ADD, ALU_SUB}))
        else $error("alu overflow raised for fn %s", fn_i.name());

endmodule

//--- verilog/mul.sv
// combinational 32x32 multiply, full 64-bit product; no pipelining
`timescale 1ns/1ps

module mul (
    input  logic [31:0] op_a_i,
    input  logic [31:0] op_b_i,
    input  logic        is_unsigned_i,
    output logic [63:0] product_o
);

    logic signed [32:0] op_a_ext;
    logic signed [32:0] op_b_ext;
    logic signed [65:0] product_full;

    // one extra bit lets a single signed multiplier do both forms
    assign op_a_ext = {~is_unsigned_i & op_a_i[31], op_a_i};
    assign op_b_ext = {~is_unsigned_i & op_b_i[31], op_b_i};

    assign product_full = op_a_ext * op_b_ext;

    assign product_o = product_full[63:0];

endmodule

//--- verilog/count_bit_word.sv
// combinational; returns 32 when every bit equals bit_i
`timescale 1ns/1ps

module count_bit_word (
    input  logic [31:0] data_i,
    input  logic        bit_i,
    output logic [31:0] cnt_o
);

    logic [5:0] cnt;
    logic       run;

    // scan from the msb, stop counting at the first mismatch
    always_comb begin
        cnt = 6'd0;
        run = 1'b1;
        for (int i = 31; i >= 0; i--) begin
            if (run && (data_i[i] == bit_i)) begin
                cnt = cnt + 6'd1;
            end else begin
                run = 1'b0;
            end
        end
    end

    assign cnt_o = {26'b0, cnt};

endmodule

//--- verilog/ex_pkg.sv
// 32-bit datapath only; DIV and MFC0 decode as bubbles, LL/SC behave as LW/SW
package ex_pkg;

    // link register for JAL, BGEZAL and BLTZAL
    localparam logic [4:0] REG_LINK = 5'd31;

    // --------------------
    // opcodes and encodings
    // --------------------
    typedef enum logic [7:0] {
        OP_NOP = 8'd0,
        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_NOR, OP_SLT,
        OP_SLL, OP_SRL, OP_SRA, OP_SLLV, OP_SRLV, OP_SRAV,
        OP_LUI,
        OP_LB, OP_LH, OP_LW, OP_LL, OP_SB, OP_SH, OP_SW, OP_SC,
        OP_JAL, OP_JALR, OP_BGEZAL, OP_BLTZAL,
        OP_MFHI, OP_MFLO, OP_MTHI, OP_MTLO,
        OP_MUL, OP_MULT,
        OP_CLO, OP_CLZ,
        OP_MOVN, OP_MOVZ,
        OP_DIV, OP_MFC0
    } op_e;

    typedef enum logic [1:0] {OPT_R, OPT_I, OPT_J} op_type_e;

    typedef enum logic [1:0] {ACC_D2R, ACC_M2R, ACC_R2M} access_op_e;

    typedef enum logic [1:0] {SZ_BYTE, SZ_HALF, SZ_WORD} access_sz_e;

    typedef enum logic [4:0] {
        ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU,
        ALU_SLT, ALU_SLTU,
        ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLLV, ALU_SRLV, ALU_SRAV
    } alu_fn_e;

    // second alu operand
    typedef enum logic [1:0] {OPND_REG, OPND_SEXT, OPND_ZEXT} opnd_e;

    // eleven sources, so four bits
    typedef enum logic [3:0] {
        RES_ALU, RES_MUL_LO, RES_CLO, RES_CLZ, RES_HI, RES_LO,
        RES_LINK, RES_LUI, RES_RS, RES_RT, RES_ZERO
    } res_src_e;

    typedef enum logic [1:0] {HILO_NONE, HILO_HI, HILO_LO, HILO_BOTH} hilo_wr_e;

    // --------------------
    // stage structs
    // --------------------
    typedef struct packed {
        op_e         op;
        op_type_e    op_type;
        logic [31:0] link_addr;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [31:0] rs_value;
        logic [31:0] rt_value;
        logic [15:0] imm;
        logic        is_unsigned;
    } ex_in_t;

    typedef struct packed {
        access_op_e  mem_access_op;
        access_sz_e  mem_access_sz;
        logic [31:0] data;
        logic [31:0] mem_addr;
        logic [4:0]  reg_addr;
        logic        overflow;
    } ex_out_t;

    // what a bubble looks like on the output
    localparam ex_out_t EX_OUT_BUBBLE = '{
        mem_access_op: ACC_D2R,
        mem_access_sz: SZ_WORD,
        data:          32'h0,
        mem_addr:      32'h0,
        reg_addr:      5'h0,
        overflow:      1'b0
    };

endpackage
